// File: design/cycle_sequencer.sv
// execute stage of the sequencer
// walks the cycle states for each decoded word, runs the group step loop
// and keeps the premodification counter with its pending sum
`include "pm_defines.svh"

module cycle_sequencer (
	input  logic        setwp,
	input  logic        __m77,
	pm_dec_if.exe       dec,
	output logic        busy,
	output logic [2:0]  step,
	output logic        wr_stb,
	output logic        done,
	output logic        illegal,
	output logic [1:0]  mc,
	output logic [15:0] premod_sum
);
	import pm_pkg::*;

	pm_state_e  state_q;
	pm_state_e  state;
	pm_state_e  state_nx;
	logic [2:0] last_step;
	logic       md_full;
	logic       finish;

	// the cycle with a fresh word on the bus is the argument resolve cycle
	assign state = (state_q == S_IDLE && dec.valid) ? S_P1 : state_q;

	// count is A+1 modulo 8, so A=7 still ends on step 7
	assign last_step = dec.count - 3'd1;
	assign md_full   = (mc == 2'(`PM_MC_MAX));

	always_comb begin
		state_nx = state;
		case (state)
			S_IDLE: state_nx = S_IDLE;
			S_P1:   state_nx = (dec.cls == CL_GROUP) ? S_W : S_P5;
			S_P5:   state_nx = S_DONE;
			S_W: begin
				if (step == last_step)
					state_nx = S_DONE;
			end
			S_DONE: state_nx = S_IDLE;
			default: state_nx = S_IDLE;
		endcase
	end

	// edge on which done rises
	assign finish = (state != S_DONE) && (state_nx == S_DONE);

	always_ff @(posedge setwp or posedge __m77) begin
		if (__m77) begin
			state_q    <= S_IDLE;
			step       <= 3'd0;
			illegal    <= 1'b0;
			mc         <= 2'd0;
			premod_sum <= 16'd0;
		end else begin
			state_q <= state_nx;

			if (state == S_W && state_nx == S_W)
				step <= step + 3'd1;
			else
				step <= 3'd0;

			illegal <= finish &&
				(dec.cls == CL_ILLEGAL || (dec.cls == CL_MD && md_full));

			// arg of an MD already holds the old sum plus its own argument
			if (finish) begin
				if (dec.cls == CL_MD) begin
					if (!md_full) begin
						mc         <= mc + 2'd1;
						premod_sum <= dec.arg;
					end
				end else begin
					mc         <= 2'd0;
					premod_sum <= 16'd0;
				end
			end
		end
	end

	assign busy = (state == S_P1) || (state == S_P5) || (state == S_W);
	assign done = (state_q == S_DONE);

	// single write in P5, one write per group step
	assign wr_stb = (state == S_W) ||
		(state == S_P5 &&
			(dec.cls == CL_LOAD || dec.cls == CL_SHORT_ADD || dec.cls == CL_JUMP));

	// P1 only lasts while valid is up, it is never held in the register
	a_state_legal: assert property (
		@(posedge setwp) disable iff (__m77)
		state_q inside {S_IDLE, S_P5, S_W, S_DONE}
	);

	// a full counter is only left when a word other than MD finishes
	a_mc_no_wrap: assert property (
		@(posedge setwp) disable iff (__m77)
		($past(mc) == 2'(`PM_MC_MAX) && mc != 2'(`PM_MC_MAX)) |->
			$past(finish && dec.cls != CL_MD)
	);

endmodule

// File: design/instr_decode.sv
// decode stage of the sequencer
// captures a strobed word and its operand, then one edge later presents
// class, register field, effective argument and group count on the bus
`include "pm_defines.svh"

module instr_decode (
	input  logic        setwp,
	input  logic        __m77,
	input  logic        instr_stb,
	input  logic [15:0] instr,
	input  logic [15:0] operand,
	input  logic [15:0] premod_sum,
	input  logic        busy,
	pm_dec_if.dec       dec
);
	import pm_pkg::*;

	logic        pend_q;
	pm_instr_u   ir_q;
	logic [15:0] opr_q;
	logic        accept;
	pm_class_e   cls_c;
	logic        short_c;
	logic [2:0]  areg_c;
	logic [15:0] base_c;

	// drop strobes while executing or while a word waits for decode
	assign accept = instr_stb && !busy && !pend_q;

	always_ff @(posedge setwp or posedge __m77) begin
		if (__m77) begin
			pend_q    <= 1'b0;
			dec.valid <= 1'b0;
		end else begin
			pend_q    <= accept;
			dec.valid <= pend_q;
		end
	end

	always_ff @(posedge setwp) begin
		if (accept) begin
			ir_q  <= instr;
			opr_q <= operand;
		end
		if (pend_q) begin
			dec.cls   <= cls_c;
			dec.areg  <= areg_c;
			dec.arg   <= base_c + premod_sum;
			dec.count <= areg_c + 3'd1;
		end
	end

	// opcode field sits in the same place in both layouts
	always_comb begin
		case (ir_q.n.opcode)
			`PM_OP_LW:  cls_c = CL_LOAD;
			`PM_OP_AWT: cls_c = CL_SHORT_ADD;
			`PM_OP_UJ:  cls_c = CL_JUMP;
			`PM_OP_LF:  cls_c = CL_GROUP;
			`PM_OP_MD:  cls_c = CL_MD;
			default:    cls_c = CL_ILLEGAL;
		endcase
	end

	// AWT and UJ carry T in the word, the rest take the operand word
	assign short_c = (cls_c == CL_SHORT_ADD) || (cls_c == CL_JUMP);
	assign areg_c  = short_c ? ir_q.s.a : ir_q.n.a;
	assign base_c  = short_c ?
		{{(`PM_WORD - `PM_T_BITS){ir_q.s.t[`PM_T_BITS-1]}}, ir_q.s.t} : opr_q;

	// a word only reaches the bus if the sequencer was idle when it was taken
	a_valid_when_idle: assert property (
		@(posedge setwp) disable iff (__m77)
		$rose(dec.valid) |-> $past(!busy, 2)
	);

endmodule

// File: design/pm_dec_if.sv
// decoded instruction bus between the decode, execute and result stages
// decode drives it, execute reads all of it, result reads what it writes back
interface pm_dec_if;
	import pm_pkg::*;

	// one-cycle strobe, the other fields hold until the next word
	logic        valid;
	pm_class_e   cls;
	logic [2:0]  areg;
	// effective argument, premodification already added
	logic [15:0] arg;
	// group length, A+1
	logic [2:0]  count;

	modport dec (
		output valid, cls, areg, arg, count
	);

	modport exe (
		input valid, cls, areg, arg, count
	);

	modport res (
		input cls, areg, arg
	);

endinterface

// File: design/pm_defines.svh
// opcode numbers and field widths for the microinstruction sequencer
// include wherever opcodes, word size or the premodification limit are needed
`ifndef PM_DEFINES_SVH
`define PM_DEFINES_SVH

// data path and instruction word size
`define PM_WORD 16

// field widths of the instruction word, msb first
`define PM_OP_BITS  6
`define PM_REG_BITS 3
`define PM_T_BITS   7

// opcode numbers
`define PM_OP_LW  6'o20
`define PM_OP_LF  6'o27
`define PM_OP_AWT 6'o40
`define PM_OP_UJ  6'o70
`define PM_OP_MD  6'o72

// premodifications allowed before the next MD is refused
`define PM_MC_MAX 3

`endif

// File: design/pm_pkg.sv
// shared types of the sequencer
// instruction word views, cycle states and opcode classes
`include "pm_defines.svh"

package pm_pkg;

	// one instruction word, read either in normal or in short-argument layout
	typedef union packed {
		struct packed {
			logic [`PM_OP_BITS-1:0]  opcode;
			logic                    d;
			logic [`PM_REG_BITS-1:0] a;
			logic [`PM_REG_BITS-1:0] b;
			logic [`PM_REG_BITS-1:0] c;
		} n;
		struct packed {
			logic [`PM_OP_BITS-1:0]  opcode;
			logic [`PM_REG_BITS-1:0] a;
			logic [`PM_T_BITS-1:0]   t;
		} s;
	} pm_instr_u;

	// cycle states
	typedef enum logic [2:0] {
		S_IDLE,
		S_P1,
		S_P5,
		S_W,
		S_DONE
	} pm_state_e;

	// opcode classes after decode
	typedef enum logic [2:0] {
		CL_MD,
		CL_LOAD,
		CL_SHORT_ADD,
		CL_JUMP,
		CL_GROUP,
		CL_ILLEGAL
	} pm_class_e;

endpackage

// File: design/pm_top.sv
// top level of the microinstruction sequencer
// words enter on instr_stb with their operand, writes leave as strobes
// on the register-file and instruction-counter ports
module pm_top (
	input  logic        setwp,
	input  logic        __m77,
	input  logic        instr_stb,
	input  logic [15:0] instr,
	input  logic [15:0] operand,
	output logic        busy,
	output logic        reg_we,
	output logic [2:0]  reg_sel,
	output logic [15:0] reg_data,
	output logic        ic_we,
	output logic [15:0] ic_data,
	output logic        done,
	output logic        illegal,
	output logic [1:0]  mc
);

	pm_dec_if dec_bus ();

	logic [15:0] premod_sum;
	logic [2:0]  step;
	logic        wr_stb;

	instr_decode u_decode (
		.setwp(setwp), .__m77(__m77), .instr_stb(instr_stb), .instr(instr),
		.operand(operand), .premod_sum(premod_sum), .busy(busy), .dec(dec_bus.dec)
	);

	cycle_sequencer u_sequencer (
		.setwp(setwp), .__m77(__m77), .dec(dec_bus.exe), .busy(busy), .step(step),
		.wr_stb(wr_stb), .done(done), .illegal(illegal), .mc(mc),
		.premod_sum(premod_sum)
	);

	write_control u_write (
		.setwp(setwp), .__m77(__m77), .dec(dec_bus.res), .step(step), .wr_stb(wr_stb),
		.reg_we(reg_we), .reg_sel(reg_sel), .reg_data(reg_data), .ic_we(ic_we),
		.ic_data(ic_data)
	);

endmodule

// File: design/write_control.sv
// result stage of the sequencer
// turns the execute write strobe into registered register-file and IC writes
// with select and data chosen by the opcode class
module write_control (
	input  logic        setwp,
	input  logic        __m77,
	pm_dec_if.res       dec,
	input  logic [2:0]  step,
	input  logic        wr_stb,
	output logic        reg_we,
	output logic [2:0]  reg_sel,
	output logic [15:0] reg_data,
	output logic        ic_we,
	output logic [15:0] ic_data
);
	import pm_pkg::*;

	logic group_c;
	logic to_reg;
	logic to_ic;

	assign group_c = (dec.cls == CL_GROUP);
	assign to_reg  = wr_stb &&
		(dec.cls == CL_LOAD || dec.cls == CL_SHORT_ADD || group_c);
	assign to_ic   = wr_stb && (dec.cls == CL_JUMP);

	always_ff @(posedge setwp or posedge __m77) begin
		if (__m77) begin
			reg_we <= 1'b0;
			ic_we  <= 1'b0;
		end else begin
			reg_we <= to_reg;
			ic_we  <= to_ic;
		end
	end

	// group writes walk the register file from reg 0 upward
	always_ff @(posedge setwp) begin
		if (to_reg) begin
			reg_sel  <= group_c ? step : dec.areg;
			reg_data <= group_c ? dec.arg + {13'd0, step} : dec.arg;
		end
		if (to_ic)
			ic_data <= dec.arg;
	end

	a_one_target: assert property (
		@(posedge setwp) disable iff (__m77)
		!(reg_we && ic_we)
	);

endmodule

// File: flist.f
+incdir+design
design/pm_pkg.sv
design/pm_dec_if.sv
design/instr_decode.sv
design/cycle_sequencer.sv
design/write_control.sv
design/pm_top.sv
verif/tb_pm.sv

// File: run_sim.sh
#!/bin/bash
# build the sequencer testbench with Verilator, run it and look for the pass line
cd "$(dirname "$0")" || exit 1
verilator --binary --timing --assert --timescale 1ns/100ps --top-module tb_pm \
	-f flist.f -o tb_pm_sim &&
	out="$(./obj_dir/tb_pm_sim)" &&
	echo "$out" &&
	echo "$out" | grep -qx "all tests passed" || exit 1

// File: verif/pm_vectors.txt
// columns: instr operand kind sel data writes illegal mc_before mc_after stray
// kind 0 no write, 1 register file, 2 IC; group writes go to sel+i with data+i
// LW normal format, reg 3 gets the operand
40C0 1234 1 3 1234 1 0 0 0 0
// AWT short format, T = -5 into reg 2
817B BEEF 1 2 FFFB 1 0 0 0 0
// MD, MD, UJ with T = 0x23, sum wraps modulo 2^16
E800 0100 0 0 0000 0 0 0 1 0
E800 FFF0 0 0 0000 0 0 1 2 0
E023 0000 2 0 0113 1 0 2 0 0
// LF with A = 5, six writes from reg 0
5D40 7FFE 1 0 7FFE 6 0 0 0 0
// three MDs fill the counter, the fourth is refused and a stray strobe is dropped
E800 0001 0 0 0000 0 0 0 1 0
E800 0002 0 0 0000 0 0 1 2 0
E800 0004 0 0 0000 0 0 2 3 0
E800 0008 0 0 0000 0 1 3 3 1
// LW on reg 1 takes the held sum of 7
4040 1000 1 1 1007 1 0 3 0 0

// File: verif/tb_pm.sv
// self-checking testbench for the microinstruction sequencer
// reads one record per instruction from verif/pm_vectors.txt, strobes the word
// into pm_top and checks every write event, done, illegal and mc
`include "pm_defines.svh"

module tb_pm;
	timeunit 1ns;
	timeprecision 100ps;

	localparam int REC_WORDS = 10;
	localparam int MAX_REC = 25;
	localparam int REC_CYCLES = 20;
	localparam logic [31:0] WORD_MASK = (32'd1 << `PM_WORD) - 32'd1;
	// jump word offered while busy, a write from it would show up as an extra event
	localparam logic [15:0] STRAY_INSTR = {`PM_OP_UJ, 10'h07f};

	logic        setwp;
	logic        __m77;
	logic        instr_stb;
	logic [15:0] instr;
	logic [15:0] operand;
	logic        busy;
	logic        reg_we;
	logic [2:0]  reg_sel;
	logic [15:0] reg_data;
	logic        ic_we;
	logic [15:0] ic_data;
	logic        done;
	logic        illegal;
	logic [1:0]  mc;

	logic [`PM_WORD-1:0] vec_mem [0:255];
	int rec_count = 0;
	int err_count = 0;
	int check_count = 0;
	int edge_count = 0;
	logic [31:0] ev_kind [$];
	logic [31:0] ev_sel [$];
	logic [31:0] ev_data [$];
	int ev_edge [$];

	pm_top uut (
		.setwp(setwp), .__m77(__m77), .instr_stb(instr_stb), .instr(instr),
		.operand(operand), .busy(busy), .reg_we(reg_we), .reg_sel(reg_sel),
		.reg_data(reg_data), .ic_we(ic_we), .ic_data(ic_data), .done(done),
		.illegal(illegal), .mc(mc)
	);

	initial begin
		setwp = 1'b0;
		forever #2 setwp = ~setwp;
	end

	always @(posedge setwp)
		edge_count++;

	// writes are picked up half a cycle after the edge that sets them
	always @(negedge setwp) begin
		if (!__m77 && reg_we) begin
			ev_kind.push_back(32'd1);
			ev_sel.push_back(32'(reg_sel));
			ev_data.push_back(32'(reg_data));
			ev_edge.push_back(edge_count);
		end
		if (!__m77 && ic_we) begin
			ev_kind.push_back(32'd2);
			ev_sel.push_back(32'd0);
			ev_data.push_back(32'(ic_data));
			ev_edge.push_back(edge_count);
		end
	end

	task automatic check_value(input string name, input logic [31:0] got,
			input logic [31:0] exp);
		check_count++;
		if (got !== exp) begin
			$display("error %s got %h expected %h", name, got, exp);
			err_count++;
		end
	endtask

	function automatic logic [31:0] vec_word(input int r, input int n);
		return 32'(vec_mem[8'(r * REC_WORDS + n)]);
	endfunction

	// words the file does not set, different at every address
	function automatic logic [15:0] fill_word(input int a);
		return {~8'(a), 8'(a)};
	endfunction

	// record columns: instr operand kind sel data writes illegal mc_before mc_after stray
	task automatic run_record(input int r);
		logic [31:0] exp_sel;
		logic [31:0] exp_data;
		int errs_before;
		int k;
		bit stray_sent;
		int stb_edges;
		int done_edges;

		errs_before = err_count;
		stray_sent = 1'b0;
		@(negedge setwp);
		check_value("mc", 32'(mc), vec_word(r, 7));
		instr = 16'(vec_word(r, 0));
		operand = 16'(vec_word(r, 1));
		instr_stb = 1'b1;
		stb_edges = edge_count;
		while (!done) begin
			@(negedge setwp);
			instr_stb = 1'b0;
			if (vec_word(r, 9) != 0 && !stray_sent && busy) begin
				instr = STRAY_INSTR;
				operand = 16'hdead;
				instr_stb = 1'b1;
				stray_sent = 1'b1;
			end
		end
		done_edges = edge_count;
		if (vec_word(r, 9) != 0 && !stray_sent) begin
			$display("record %0d: busy never rose, so no strobe was offered while busy", r);
			err_count++;
		end
		// done on edge 3, a group of n writes ends on edge n+2
		check_value("done edge", 32'(done_edges - stb_edges - 1),
			(vec_word(r, 5) > 32'd1) ? vec_word(r, 5) + 32'd2 : 32'd3);
		check_value("busy", 32'(busy), 32'd0);
		check_value("illegal", 32'(illegal), vec_word(r, 6));
		@(negedge setwp);
		check_value("done", 32'(done), 32'd0);
		check_value("mc", 32'(mc), vec_word(r, 8));
		// queues only change on falling edges
		@(posedge setwp);
		check_value("write count", 32'(ev_kind.size()), vec_word(r, 5));
		for (k = 0; k < ev_kind.size() && k < int'(vec_word(r, 5)); k++) begin
			exp_sel = vec_word(r, 3) + 32'(k);
			exp_data = (vec_word(r, 4) + 32'(k)) & WORD_MASK;
			check_value("write kind", ev_kind[k], vec_word(r, 2));
			// writes on consecutive edges, the last one together with done
			check_value("write edge", 32'(ev_edge[k]),
				32'(done_edges - int'(vec_word(r, 5)) + 1 + k));
			if (vec_word(r, 2) == 32'd2) begin
				check_value("ic_data", ev_data[k], exp_data);
			end else begin
				check_value("reg_sel", ev_sel[k], exp_sel);
				check_value("reg_data", ev_data[k], exp_data);
			end
		end
		ev_kind.delete();
		ev_sel.delete();
		ev_data.delete();
		ev_edge.delete();
		if (err_count == errs_before)
			$display("record %0d ok", r);
		else
			$display("record %0d mismatch", r);
	endtask

	initial begin
		int i;
		int n;

		instr_stb = 1'b0;
		instr = 16'd0;
		operand = 16'd0;
		__m77 = 1'b1;
		for (i = 0; i < 256; i++)
			vec_mem[8'(i)] = fill_word(i);
		$readmemh("verif/pm_vectors.txt", vec_mem);
		// a record the file did not reach still holds the fill pattern
		n = 0;
		while (n < MAX_REC && vec_word(n, 0) != 32'(fill_word(n * REC_WORDS)))
			n++;
		rec_count = n;
		repeat (8) @(negedge setwp);
		__m77 = 1'b0;
		@(negedge setwp);
		check_value("busy", 32'(busy), 32'd0);
		check_value("reg_we", 32'(reg_we), 32'd0);
		check_value("ic_we", 32'(ic_we), 32'd0);
		check_value("done", 32'(done), 32'd0);
		check_value("illegal", 32'(illegal), 32'd0);
		check_value("mc", 32'(mc), 32'd0);
		if (n == 0) begin
			$display("no vector records could be read");
			err_count++;
		end
		for (i = 0; i < n; i++)
			run_record(i);
		// a dropped strobe must not turn up later as a write
		repeat (4) @(negedge setwp);
		@(posedge setwp);
		check_value("late writes", 32'(ev_kind.size()), 32'd0);
		$display("%0d records, %0d checks, %0d errors", n, check_count, err_count);
		if (err_count == 0)
			$display("all tests passed");
		else
			$display("tests failed");
		$finish;
	end

	// watchdog, sized from the record count
	initial begin
		wait (rec_count > 0);
		repeat (16 + rec_count * REC_CYCLES) @(posedge setwp);
		$display("timeout: the sequencer did not finish all records in time");
		$display("tests failed");
		$finish;
	end

endmodule
